//--- verilog/mini16_fabric_pkg.sv
`default_nettype none

package mini16_fabric_pkg;

  // Word widths
  localparam int WIDTH_I = 16;
  localparam int WIDTH_D = 32;

  // I/O register window, 32 words
  localparam int DEPTH_IO_REG = 5;

  // Bank field sits right above the offset
  localparam int BANK_BITS = 3;

  // Master write banks, anything else selects a single PE
  typedef enum logic [BANK_BITS-1:0] {
    MW_MEM_D     = 3'd0,
    MW_IO_REG    = 3'd1,
    MW_BROADCAST = 3'd7
  } master_w_bank_e;

  typedef enum logic [BANK_BITS-1:0] {
    MR_MEM_D  = 3'd0,
    MR_IO_REG = 3'd1,
    MR_U2M    = 3'd2,
    MR_S2M    = 3'd3
  } master_r_bank_e;

  // Loader banks; offset 0 of LD_CTRL is the master reset word
  typedef enum logic [BANK_BITS-1:0] {
    LD_MEM_I = 3'd0,
    LD_CTRL  = 3'd1,
    LD_U2M   = 3'd2
  } loader_bank_e;

  typedef enum logic [0:0] {
    CB_S2M  = 1'b0,
    CB_VRAM = 1'b1
  } collector_bank_e;

  typedef enum logic [DEPTH_IO_REG-1:0] {
    IOW_RESET_PE = 5'd0,
    IOW_LED      = 5'd1,
    IOW_UART     = 5'd2
  } io_w_reg_e;

  typedef enum logic [DEPTH_IO_REG-1:0] {
    IOR_UART_BUSY = 5'd0
  } io_r_reg_e;

endpackage

`default_nettype wire

//--- verilog/mini16_dp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module mini16_dp_ram
  #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 8
    )
  (
   input  wire                   clk,
   input  wire [ADDR_WIDTH-1:0]  addr_r,
   input  wire [ADDR_WIDTH-1:0]  addr_w,
   input  wire [DATA_WIDTH-1:0]  data_in,
   input  wire                   we,
   output logic [DATA_WIDTH-1:0] data_out
   );

  logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1];

  // Read returns the old word on a same-address write
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[addr_w] <= data_in;
    end
    data_out <= mem[addr_r];
  end

  a_addr_w_known: assert property (@(posedge clk) we |-> !$isunknown(addr_w))
    else $error("RAM write with unknown address");

endmodule

`default_nettype wire

//--- verilog/mini16_io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mini16_io_regs
  (
   input  wire                                          clk,
   input  wire                                          rst_n,
   input  wire                                          io_we,
   input  wire mini16_fabric_pkg::io_w_reg_e            w_addr,
   input  wire [mini16_fabric_pkg::WIDTH_D-1:0]         w_data,
   input  wire [mini16_fabric_pkg::DEPTH_IO_REG-1:0]    r_addr,
   input  wire                                          uart_busy,
   output logic [mini16_fabric_pkg::WIDTH_D-1:0]        r_data,
   output logic [15:0]                                  led,
   output logic                                         pe_reset,
   output logic [7:0]                                   uart_tx_data,
   output logic                                         uart_tx_we
   );

  import mini16_fabric_pkg::*;

  logic             io_we_q;
  io_w_reg_e        w_addr_q;
  logic [WIDTH_D-1:0] w_data_q;
  logic             uart_wr_q;
  logic             uart_hit;

  // Internal write stage
  always_ff @(posedge clk)
  begin
    w_addr_q <= w_addr;
    w_data_q <= w_data;
  end

  assign uart_hit = io_we_q && (w_addr_q == IOW_UART);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      io_we_q <= 1'b0;
      led <= '0;
      pe_reset <= 1'b0;
      uart_tx_data <= '0;
      uart_wr_q <= 1'b0;
      uart_tx_we <= 1'b0;
    end
    else
    begin
      io_we_q <= io_we;
      if (io_we_q)
      begin
        case (w_addr_q)
          IOW_RESET_PE: pe_reset <= w_data_q[0];
          IOW_LED: led <= w_data_q[15:0];
          IOW_UART: uart_tx_data <= w_data_q[7:0];
          default: ;
        endcase
      end
      // Pulse goes out once the byte is already in place
      uart_wr_q <= uart_hit;
      uart_tx_we <= uart_wr_q;
    end
  end

  // Only the busy flag is readable
  always_ff @(posedge clk)
  begin
    r_data <= (r_addr == IOR_UART_BUSY) ? {{(WIDTH_D-1){1'b0}}, uart_busy} : '0;
  end

  a_tx_we_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    (uart_tx_we && $past(uart_tx_we))
      |-> ($past(io_we && (w_addr == IOW_UART), 3)
           && $past(io_we && (w_addr == IOW_UART), 4)))
    else $error("uart_tx_we held without back to back UART writes");

endmodule

`default_nettype wire

//--- verilog/mini16_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module mini16_read_mux
  (
   input  wire                                   clk,
   input  wire mini16_fabric_pkg::master_r_bank_e rd_bank_q,
   input  wire [mini16_fabric_pkg::WIDTH_D-1:0]  mem_d_data,
   input  wire [mini16_fabric_pkg::WIDTH_D-1:0]  io_data,
   input  wire [mini16_fabric_pkg::WIDTH_D-1:0]  u2m_data,
   input  wire [mini16_fabric_pkg::WIDTH_D-1:0]  s2m_data,
   output logic [mini16_fabric_pkg::WIDTH_D-1:0] d_r_data
   );

  import mini16_fabric_pkg::*;

  // Sources are one cycle behind the address, so is the bank
  always_ff @(posedge clk)
  begin
    case (rd_bank_q)
      MR_MEM_D:
      begin
        d_r_data <= mem_d_data;
      end
      MR_IO_REG:
      begin
        d_r_data <= io_data;
      end
      MR_U2M:
      begin
        d_r_data <= u2m_data;
      end
      // s2m and every unused bank
      default:
      begin
        d_r_data <= s2m_data;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/mini16_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mini16_bus_ctrl
  #(
    parameter int DEPTH_OFS = 8,
    localparam int M_ADDR_W = mini16_fabric_pkg::BANK_BITS + DEPTH_OFS,
    localparam int LD_ADDR_W = mini16_fabric_pkg::BANK_BITS + DEPTH_OFS,
    localparam int COL_ADDR_W = 1 + DEPTH_OFS
    )
  (
   input  wire                                   clk,
   input  wire                                   rst_n,
   input  wire [M_ADDR_W-1:0]                    d_w_addr,
   input  wire [mini16_fabric_pkg::WIDTH_D-1:0]  d_w_data,
   input  wire                                   d_we,
   input  wire [M_ADDR_W-1:0]                    d_r_addr,
   input  wire [LD_ADDR_W-1:0]                   ld_addr,
   input  wire [mini16_fabric_pkg::WIDTH_D-1:0]  ld_data,
   input  wire                                   ld_we,
   input  wire [COL_ADDR_W-1:0]                  col_addr,
   input  wire [mini16_fabric_pkg::WIDTH_D-1:0]  col_data,
   input  wire                                   col_we,
   output logic                                  mem_d_we,
   output logic                                  mem_i_we,
   output logic                                  u2m_we,
   output logic                                  s2m_we,
   output logic                                  io_we,
   output logic [M_ADDR_W-1:0]                   w_addr_q,
   output logic [mini16_fabric_pkg::WIDTH_D-1:0] w_data_q,
   output logic [DEPTH_OFS-1:0]                  ld_addr_q,
   output logic [mini16_fabric_pkg::WIDTH_D-1:0] ld_data_q,
   output logic [DEPTH_OFS-1:0]                  col_addr_q,
   output logic [mini16_fabric_pkg::WIDTH_D-1:0] col_data_q,
   output mini16_fabric_pkg::master_r_bank_e     rd_bank_q,
   output logic                                  master_reset,
   output logic [M_ADDR_W-1:0]                   pe_w_addr,
   output logic [mini16_fabric_pkg::WIDTH_D-1:0] pe_w_data,
   output logic                                  pe_we
   );

  import mini16_fabric_pkg::*;

  master_w_bank_e  w_bank;
  master_r_bank_e  r_bank;
  loader_bank_e    ld_bank;
  collector_bank_e col_bank;
  logic            ld_ctrl_hit;
  logic            ctrl_we;

  // Bank fields above the offsets
  assign w_bank = master_w_bank_e'(d_w_addr[M_ADDR_W-1 -: BANK_BITS]);
  assign r_bank = master_r_bank_e'(d_r_addr[M_ADDR_W-1 -: BANK_BITS]);
  assign ld_bank = loader_bank_e'(ld_addr[LD_ADDR_W-1 -: BANK_BITS]);
  assign col_bank = collector_bank_e'(col_addr[COL_ADDR_W-1]);

  // Master reset word lives at offset 0 of the control bank
  assign ld_ctrl_hit = ld_we && (ld_bank == LD_CTRL) && (ld_addr[DEPTH_OFS-1:0] == '0);

  // One registered strobe per target
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mem_d_we <= 1'b0;
      io_we <= 1'b0;
      pe_we <= 1'b0;
      mem_i_we <= 1'b0;
      u2m_we <= 1'b0;
      ctrl_we <= 1'b0;
      s2m_we <= 1'b0;
      rd_bank_q <= MR_MEM_D;
    end
    else
    begin
      mem_d_we <= d_we && (w_bank == MW_MEM_D);
      io_we <= d_we && (w_bank == MW_IO_REG);
      // PEs see every master write and filter by bank themselves
      pe_we <= d_we;
      mem_i_we <= ld_we && (ld_bank == LD_MEM_I);
      u2m_we <= ld_we && (ld_bank == LD_U2M);
      ctrl_we <= ld_ctrl_hit;
      // VRAM bank is dropped here
      s2m_we <= col_we && (col_bank == CB_S2M);
      rd_bank_q <= r_bank;
    end
  end

  // Addresses and data follow their strobes by one cycle
  always_ff @(posedge clk)
  begin
    w_addr_q <= d_w_addr;
    w_data_q <= d_w_data;
    ld_addr_q <= ld_addr[DEPTH_OFS-1:0];
    ld_data_q <= ld_data;
    col_addr_q <= col_addr[DEPTH_OFS-1:0];
    col_data_q <= col_data;
  end

  // Soft reset flag, holds until the next control write
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      master_reset <= 1'b0;
    end
    else if (ctrl_we)
    begin
      master_reset <= ld_data_q[0];
    end
  end

  assign pe_w_addr = w_addr_q;
  assign pe_w_data = w_data_q;

  // The master bus can only hit one local target per cycle
  a_master_w_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0({mem_d_we, io_we}))
    else $error("mem_d_we and io_we both high");

  a_loader_w_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0({mem_i_we, u2m_we}))
    else $error("mem_i_we and u2m_we both high");

endmodule

`default_nettype wire

//--- verilog/mini16_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module mini16_fabric
  #(
    parameter int DEPTH_M_I = 8,
    parameter int DEPTH_M_D = 8,
    parameter int DEPTH_U2M = 8,
    parameter int DEPTH_S2M = 8,
    // Must cover the deepest memory
    parameter int DEPTH_OFS = 8,
    localparam int M_ADDR_W = mini16_fabric_pkg::BANK_BITS + DEPTH_OFS,
    localparam int LD_ADDR_W = mini16_fabric_pkg::BANK_BITS + DEPTH_OFS,
    localparam int COL_ADDR_W = 1 + DEPTH_OFS
    )
  (
   input  wire                                   clk,
   input  wire                                   rst_n,
   input  wire [DEPTH_M_I-1:0]                   i_r_addr,
   output logic [mini16_fabric_pkg::WIDTH_I-1:0] i_r_data,
   input  wire [M_ADDR_W-1:0]                    d_r_addr,
   output logic [mini16_fabric_pkg::WIDTH_D-1:0] d_r_data,
   input  wire [M_ADDR_W-1:0]                    d_w_addr,
   input  wire [mini16_fabric_pkg::WIDTH_D-1:0]  d_w_data,
   input  wire                                   d_we,
   input  wire [LD_ADDR_W-1:0]                   ld_addr,
   input  wire [mini16_fabric_pkg::WIDTH_D-1:0]  ld_data,
   input  wire                                   ld_we,
   input  wire [COL_ADDR_W-1:0]                  col_addr,
   input  wire [mini16_fabric_pkg::WIDTH_D-1:0]  col_data,
   input  wire                                   col_we,
   input  wire                                   uart_busy,
   output logic [15:0]                           led,
   output logic                                  pe_reset,
   output logic [7:0]                            uart_tx_data,
   output logic                                  uart_tx_we,
   output logic                                  master_reset,
   output logic [M_ADDR_W-1:0]                   pe_w_addr,
   output logic [mini16_fabric_pkg::WIDTH_D-1:0] pe_w_data,
   output logic                                  pe_we
   );

  import mini16_fabric_pkg::*;

  logic                 mem_d_we;
  logic                 mem_i_we;
  logic                 u2m_we;
  logic                 s2m_we;
  logic                 io_we;
  logic [M_ADDR_W-1:0]  w_addr_q;
  logic [WIDTH_D-1:0]   w_data_q;
  logic [DEPTH_OFS-1:0] ld_addr_q;
  logic [WIDTH_D-1:0]   ld_data_q;
  logic [DEPTH_OFS-1:0] col_addr_q;
  logic [WIDTH_D-1:0]   col_data_q;
  master_r_bank_e       rd_bank_q;
  logic [WIDTH_D-1:0]   mem_d_r_data;
  logic [WIDTH_D-1:0]   io_r_data;
  logic [WIDTH_D-1:0]   u2m_r_data;
  logic [WIDTH_D-1:0]   s2m_r_data;

  mini16_bus_ctrl
    #(
      .DEPTH_OFS (DEPTH_OFS)
      )
  bus_ctrl_i
    (
     .clk (clk),
     .rst_n (rst_n),
     .d_w_addr (d_w_addr),
     .d_w_data (d_w_data),
     .d_we (d_we),
     .d_r_addr (d_r_addr),
     .ld_addr (ld_addr),
     .ld_data (ld_data),
     .ld_we (ld_we),
     .col_addr (col_addr),
     .col_data (col_data),
     .col_we (col_we),
     .mem_d_we (mem_d_we),
     .mem_i_we (mem_i_we),
     .u2m_we (u2m_we),
     .s2m_we (s2m_we),
     .io_we (io_we),
     .w_addr_q (w_addr_q),
     .w_data_q (w_data_q),
     .ld_addr_q (ld_addr_q),
     .ld_data_q (ld_data_q),
     .col_addr_q (col_addr_q),
     .col_data_q (col_data_q),
     .rd_bank_q (rd_bank_q),
     .master_reset (master_reset),
     .pe_w_addr (pe_w_addr),
     .pe_w_data (pe_w_data),
     .pe_we (pe_we)
     );

  // Instruction memory, filled by the loader
  mini16_dp_ram
    #(
      .DATA_WIDTH (WIDTH_I),
      .ADDR_WIDTH (DEPTH_M_I)
      )
  mem_i
    (
     .clk (clk),
     .addr_r (i_r_addr),
     .addr_w (ld_addr_q[DEPTH_M_I-1:0]),
     .data_in (ld_data_q[WIDTH_I-1:0]),
     .we (mem_i_we),
     .data_out (i_r_data)
     );

  mini16_dp_ram
    #(
      .DATA_WIDTH (WIDTH_D),
      .ADDR_WIDTH (DEPTH_M_D)
      )
  mem_d
    (
     .clk (clk),
     .addr_r (d_r_addr[DEPTH_M_D-1:0]),
     .addr_w (w_addr_q[DEPTH_M_D-1:0]),
     .data_in (w_data_q),
     .we (mem_d_we),
     .data_out (mem_d_r_data)
     );

  // Loader to master buffer
  mini16_dp_ram
    #(
      .DATA_WIDTH (WIDTH_D),
      .ADDR_WIDTH (DEPTH_U2M)
      )
  u2m
    (
     .clk (clk),
     .addr_r (d_r_addr[DEPTH_U2M-1:0]),
     .addr_w (ld_addr_q[DEPTH_U2M-1:0]),
     .data_in (ld_data_q),
     .we (u2m_we),
     .data_out (u2m_r_data)
     );

  // Collector to master buffer
  mini16_dp_ram
    #(
      .DATA_WIDTH (WIDTH_D),
      .ADDR_WIDTH (DEPTH_S2M)
      )
  s2m
    (
     .clk (clk),
     .addr_r (d_r_addr[DEPTH_S2M-1:0]),
     .addr_w (col_addr_q[DEPTH_S2M-1:0]),
     .data_in (col_data_q),
     .we (s2m_we),
     .data_out (s2m_r_data)
     );

  mini16_io_regs io_regs_i
    (
     .clk (clk),
     .rst_n (rst_n),
     .io_we (io_we),
     .w_addr (io_w_reg_e'(w_addr_q[DEPTH_IO_REG-1:0])),
     .w_data (w_data_q),
     .r_addr (d_r_addr[DEPTH_IO_REG-1:0]),
     .uart_busy (uart_busy),
     .r_data (io_r_data),
     .led (led),
     .pe_reset (pe_reset),
     .uart_tx_data (uart_tx_data),
     .uart_tx_we (uart_tx_we)
     );

  mini16_read_mux read_mux_i
    (
     .clk (clk),
     .rd_bank_q (rd_bank_q),
     .mem_d_data (mem_d_r_data),
     .io_data (io_r_data),
     .u2m_data (u2m_r_data),
     .s2m_data (s2m_r_data),
     .d_r_data (d_r_data)
     );

endmodule

`default_nettype wire

//--- tests/mini16_fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mini16_fabric_tb;

  import mini16_fabric_pkg::*;

  localparam int DEPTH_OFS = 8;
  localparam int M_ADDR_W = BANK_BITS + DEPTH_OFS;
  localparam int COL_ADDR_W = 1 + DEPTH_OFS;
  localparam int CLK_PERIOD = 20;
  localparam int STIM_CYCLES = 450;
  // About four times the stimulus length
  localparam int MAX_CYCLES = 4 * STIM_CYCLES + 200;

  logic                  clk;
  logic                  rst_n;
  logic [DEPTH_OFS-1:0]  i_r_addr;
  logic [WIDTH_I-1:0]    i_r_data;
  logic [M_ADDR_W-1:0]   d_r_addr;
  logic [WIDTH_D-1:0]    d_r_data;
  logic [M_ADDR_W-1:0]   d_w_addr;
  logic [WIDTH_D-1:0]    d_w_data;
  logic                  d_we;
  logic [M_ADDR_W-1:0]   ld_addr;
  logic [WIDTH_D-1:0]    ld_data;
  logic                  ld_we;
  logic [COL_ADDR_W-1:0] col_addr;
  logic [WIDTH_D-1:0]    col_data;
  logic                  col_we;
  logic                  uart_busy;
  logic [15:0]           led;
  logic                  pe_reset;
  logic [7:0]            uart_tx_data;
  logic                  uart_tx_we;
  logic                  master_reset;
  logic [M_ADDR_W-1:0]   pe_w_addr;
  logic [WIDTH_D-1:0]    pe_w_data;
  logic                  pe_we;

  // Marks cycles whose read result gets checked
  logic  rd_active;
  logic  i_rd_active;
  string test_name;
  int    err_count = 0;
  int    reads_issued = 0;
  int    cycle_count = 0;

  // Reference model
  logic [WIDTH_I-1:0]    model_i [0:(1 << DEPTH_OFS)-1];
  logic [WIDTH_D-1:0]    model_d [0:(1 << DEPTH_OFS)-1];
  logic [WIDTH_D-1:0]    model_u2m [0:(1 << DEPTH_OFS)-1];
  logic [WIDTH_D-1:0]    model_s2m [0:(1 << DEPTH_OFS)-1];
  logic [15:0]           led_m;
  logic                  pe_reset_m;
  logic [7:0]            uart_m;
  logic                  master_reset_m;
  logic                  d_we_q;
  logic [M_ADDR_W-1:0]   d_w_addr_q;
  logic [WIDTH_D-1:0]    d_w_data_q;
  logic                  ld_we_q;
  logic [M_ADDR_W-1:0]   ld_addr_q;
  logic [WIDTH_D-1:0]    ld_data_q;
  logic                  col_we_q;
  logic [COL_ADDR_W-1:0] col_addr_q;
  logic [WIDTH_D-1:0]    col_data_q;
  logic                  io_we_q2;
  logic [DEPTH_IO_REG-1:0] io_addr_q2;
  logic [WIDTH_D-1:0]    io_data_q2;
  logic                  uart_wr_q3;
  logic                  exp_tx_we;
  logic                  rd_v1;
  logic                  rd_v2;
  logic [WIDTH_D-1:0]    rd_word1;
  logic [WIDTH_D-1:0]    exp_rd;
  logic                  i_v1;
  logic [WIDTH_I-1:0]    exp_i;

  mini16_fabric
    #(
      .DEPTH_OFS (DEPTH_OFS)
      )
  mini16_fabric_i
    (
     .clk (clk),
     .rst_n (rst_n),
     .i_r_addr (i_r_addr),
     .i_r_data (i_r_data),
     .d_r_addr (d_r_addr),
     .d_r_data (d_r_data),
     .d_w_addr (d_w_addr),
     .d_w_data (d_w_data),
     .d_we (d_we),
     .ld_addr (ld_addr),
     .ld_data (ld_data),
     .ld_we (ld_we),
     .col_addr (col_addr),
     .col_data (col_data),
     .col_we (col_we),
     .uart_busy (uart_busy),
     .led (led),
     .pe_reset (pe_reset),
     .uart_tx_data (uart_tx_data),
     .uart_tx_we (uart_tx_we),
     .master_reset (master_reset),
     .pe_w_addr (pe_w_addr),
     .pe_w_data (pe_w_data),
     .pe_we (pe_we)
     );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Word a master read returns for each bank
  function automatic logic [WIDTH_D-1:0] read_model(input logic [M_ADDR_W-1:0] addr,
                                                    input logic busy);
    logic [DEPTH_OFS-1:0] ofs;
    ofs = addr[DEPTH_OFS-1:0];
    case (addr[M_ADDR_W-1 -: BANK_BITS])
      MR_MEM_D: return model_d[ofs];
      MR_IO_REG: return (ofs[DEPTH_IO_REG-1:0] == IOR_UART_BUSY) ? WIDTH_D'(busy) : '0;
      MR_U2M: return model_u2m[ofs];
      default: return model_s2m[ofs];
    endcase
  endfunction

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      d_we_q <= 1'b0;
      ld_we_q <= 1'b0;
      col_we_q <= 1'b0;
      io_we_q2 <= 1'b0;
      uart_wr_q3 <= 1'b0;
      exp_tx_we <= 1'b0;
      led_m <= '0;
      pe_reset_m <= 1'b0;
      uart_m <= '0;
      master_reset_m <= 1'b0;
      rd_v1 <= 1'b0;
      rd_v2 <= 1'b0;
      i_v1 <= 1'b0;
    end
    else
    begin
      d_we_q <= d_we;
      ld_we_q <= ld_we;
      col_we_q <= col_we;
      // I/O registers change two edges after the strobe edge
      io_we_q2 <= d_we_q && (d_w_addr_q[M_ADDR_W-1 -: BANK_BITS] == MW_IO_REG);
      io_addr_q2 <= d_w_addr_q[DEPTH_IO_REG-1:0];
      io_data_q2 <= d_w_data_q;
      if (io_we_q2)
      begin
        case (io_addr_q2)
          IOW_RESET_PE: pe_reset_m <= io_data_q2[0];
          IOW_LED: led_m <= io_data_q2[15:0];
          IOW_UART: uart_m <= io_data_q2[7:0];
          default: ;
        endcase
      end
      uart_wr_q3 <= io_we_q2 && (io_addr_q2 == IOW_UART);
      exp_tx_we <= uart_wr_q3;
      if (ld_we_q && (ld_addr_q[M_ADDR_W-1 -: BANK_BITS] == LD_CTRL)
          && (ld_addr_q[DEPTH_OFS-1:0] == '0))
      begin
        master_reset_m <= ld_data_q[0];
      end
      rd_v1 <= rd_active;
      rd_v2 <= rd_v1;
      i_v1 <= i_rd_active;
    end
  end

  // Memory model reads before it writes on the same edge
  always @(posedge clk)
  begin
    d_w_addr_q <= d_w_addr;
    d_w_data_q <= d_w_data;
    ld_addr_q <= ld_addr;
    ld_data_q <= ld_data;
    col_addr_q <= col_addr;
    col_data_q <= col_data;
    if (d_we_q && (d_w_addr_q[M_ADDR_W-1 -: BANK_BITS] == MW_MEM_D))
    begin
      model_d[d_w_addr_q[DEPTH_OFS-1:0]] <= d_w_data_q;
    end
    if (ld_we_q && (ld_addr_q[M_ADDR_W-1 -: BANK_BITS] == LD_MEM_I))
    begin
      model_i[ld_addr_q[DEPTH_OFS-1:0]] <= ld_data_q[WIDTH_I-1:0];
    end
    if (ld_we_q && (ld_addr_q[M_ADDR_W-1 -: BANK_BITS] == LD_U2M))
    begin
      model_u2m[ld_addr_q[DEPTH_OFS-1:0]] <= ld_data_q;
    end
    // VRAM writes never reach s2m
    if (col_we_q && (col_addr_q[COL_ADDR_W-1] == CB_S2M))
    begin
      model_s2m[col_addr_q[DEPTH_OFS-1:0]] <= col_data_q;
    end
    rd_word1 <= read_model(d_r_addr, uart_busy);
    exp_rd <= rd_word1;
    exp_i <= model_i[i_r_addr];
  end

  task automatic report_mismatch(input string what, input logic [WIDTH_D-1:0] exp_val,
                                 input logic [WIDTH_D-1:0] act_val);
    err_count++;
    $display("Error [%s] %s expected %h actual %h", test_name, what, exp_val, act_val);
  endtask

  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    rd_v2 |-> (d_r_data === exp_rd))
    else report_mismatch("d_r_data", $sampled(exp_rd), $sampled(d_r_data));

  a_instr_data: assert property (@(posedge clk) disable iff (!rst_n)
    i_v1 |-> (i_r_data === exp_i))
    else report_mismatch("i_r_data", $sampled(exp_i), $sampled(i_r_data));

  a_pe_we: assert property (@(posedge clk) disable iff (!rst_n) pe_we === d_we_q)
    else report_mismatch("pe_we", $sampled(d_we_q), $sampled(pe_we));

  a_pe_addr: assert property (@(posedge clk) disable iff (!rst_n)
    d_we_q |-> (pe_w_addr === d_w_addr_q))
    else report_mismatch("pe_w_addr", $sampled(d_w_addr_q), $sampled(pe_w_addr));

  a_pe_data: assert property (@(posedge clk) disable iff (!rst_n)
    d_we_q |-> (pe_w_data === d_w_data_q))
    else report_mismatch("pe_w_data", $sampled(d_w_data_q), $sampled(pe_w_data));

  a_led: assert property (@(posedge clk) disable iff (!rst_n) led === led_m)
    else report_mismatch("led", $sampled(led_m), $sampled(led));

  a_pe_reset: assert property (@(posedge clk) disable iff (!rst_n) pe_reset === pe_reset_m)
    else report_mismatch("pe_reset", $sampled(pe_reset_m), $sampled(pe_reset));

  a_uart_data: assert property (@(posedge clk) disable iff (!rst_n) uart_tx_data === uart_m)
    else report_mismatch("uart_tx_data", $sampled(uart_m), $sampled(uart_tx_data));

  a_uart_we: assert property (@(posedge clk) disable iff (!rst_n) uart_tx_we === exp_tx_we)
    else report_mismatch("uart_tx_we", $sampled(exp_tx_we), $sampled(uart_tx_we));

  a_master_reset: assert property (@(posedge clk) disable iff (!rst_n)
    master_reset === master_reset_m)
    else report_mismatch("master_reset", $sampled(master_reset_m), $sampled(master_reset));

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Reads issued %0d, errors %0d", reads_issued, err_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Next drive point where strobes drop unless driven again
  task automatic next_cycle();
    @(posedge clk);
    #2;
    d_we = 1'b0;
    ld_we = 1'b0;
    col_we = 1'b0;
    rd_active = 1'b0;
    i_rd_active = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic master_write(input logic [BANK_BITS-1:0] bank, input logic [7:0] ofs,
                              input logic [WIDTH_D-1:0] data);
    next_cycle();
    d_w_addr = {bank, ofs};
    d_w_data = data;
    d_we = 1'b1;
  endtask

  // Joins a read to the current cycle
  task automatic add_read(input logic [BANK_BITS-1:0] bank, input logic [7:0] ofs);
    d_r_addr = {bank, ofs};
    rd_active = 1'b1;
    reads_issued++;
  endtask

  task automatic master_read(input logic [BANK_BITS-1:0] bank, input logic [7:0] ofs);
    next_cycle();
    add_read(bank, ofs);
  endtask

  task automatic instr_read(input logic [7:0] addr);
    next_cycle();
    i_r_addr = addr;
    i_rd_active = 1'b1;
    reads_issued++;
  endtask

  task automatic loader_write(input logic [BANK_BITS-1:0] bank, input logic [7:0] ofs,
                              input logic [WIDTH_D-1:0] data);
    next_cycle();
    ld_addr = {bank, ofs};
    ld_data = data;
    ld_we = 1'b1;
  endtask

  task automatic collector_write(input logic bank, input logic [7:0] ofs,
                                 input logic [WIDTH_D-1:0] data);
    next_cycle();
    col_addr = {bank, ofs};
    col_data = data;
    col_we = 1'b1;
  endtask

  initial
  begin
    logic [7:0] offs[$];
    logic [7:0] ofs;
    void'($urandom(32'h93151d02));
    rst_n = 1'b0;
    i_r_addr = '0;
    d_r_addr = '0;
    d_w_addr = '0;
    d_w_data = '0;
    d_we = 1'b0;
    ld_addr = '0;
    ld_data = '0;
    ld_we = 1'b0;
    col_addr = '0;
    col_data = '0;
    col_we = 1'b0;
    uart_busy = 1'b0;
    rd_active = 1'b0;
    i_rd_active = 1'b0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_name = "mem_d";
    for (int i = 0; i < 40; i++)
    begin
      ofs = 8'($urandom);
      offs.push_back(ofs);
      master_write(MW_MEM_D, ofs, $urandom);
    end
    foreach (offs[j])
      master_read(MR_MEM_D, offs[j]);
    // Same-word write and read return old data
    for (int i = 0; i < 8; i++)
    begin
      master_write(MW_MEM_D, offs[i], $urandom);
      add_read(MR_MEM_D, offs[i]);
    end
    // PE banks and broadcast only show on the PE outputs
    for (int i = 0; i < 6; i++)
      master_write(3'($urandom_range(7, 2)), 8'($urandom), $urandom);
    idle(6);

    test_name = "io_led";
    for (int i = 0; i < 8; i++)
    begin
      master_write(MW_IO_REG, 8'(IOW_LED), $urandom);
      master_write(MW_IO_REG, 8'(IOW_RESET_PE), $urandom);
    end
    master_write(MW_IO_REG, 8'd5, $urandom);
    idle(6);

    test_name = "uart_tx";
    for (int i = 0; i < 6; i++)
    begin
      master_write(MW_IO_REG, 8'(IOW_UART), $urandom);
      idle(3);
    end
    master_write(MW_IO_REG, 8'(IOW_UART), $urandom);
    master_write(MW_IO_REG, 8'(IOW_UART), $urandom);
    for (int i = 0; i < 8; i++)
    begin
      master_read(MR_IO_REG, 8'(IOR_UART_BUSY));
      uart_busy = 1'($urandom);
    end
    master_read(MR_IO_REG, 8'd3);
    idle(6);

    test_name = "loader";
    offs.delete();
    for (int i = 0; i < 30; i++)
    begin
      ofs = 8'($urandom);
      offs.push_back(ofs);
      loader_write(LD_MEM_I, ofs, $urandom);
    end
    foreach (offs[j])
      instr_read(offs[j]);
    offs.delete();
    for (int i = 0; i < 20; i++)
    begin
      ofs = 8'($urandom);
      offs.push_back(ofs);
      loader_write(LD_U2M, ofs, $urandom);
    end
    foreach (offs[j])
      master_read(MR_U2M, offs[j]);
    idle(6);

    test_name = "master_reset";
    for (int i = 0; i < 6; i++)
    begin
      loader_write(LD_CTRL, 8'd0, $urandom);
      idle(3);
    end
    // Clear the flag so a stray set shows up
    loader_write(LD_CTRL, 8'd0, 32'h0);
    idle(3);
    // Other control offsets leave the flag alone
    loader_write(LD_CTRL, 8'd1, 32'h1);
    idle(4);

    test_name = "collector";
    offs.delete();
    for (int i = 0; i < 20; i++)
    begin
      ofs = 8'($urandom);
      offs.push_back(ofs);
      collector_write(CB_S2M, ofs, $urandom);
    end
    foreach (offs[j])
      collector_write(CB_VRAM, offs[j], $urandom);
    foreach (offs[j])
      master_read(MR_S2M, offs[j]);
    idle(6);

    $display("Reads issued %0d, errors %0d", reads_issued, err_count);
    if (err_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- mini16_fabric.f
verilog/mini16_fabric_pkg.sv
verilog/mini16_dp_ram.sv
verilog/mini16_io_regs.sv
verilog/mini16_read_mux.sv
verilog/mini16_bus_ctrl.sv
verilog/mini16_fabric.sv
tests/mini16_fabric_tb.sv
